//--- rtl/vec_geom_pkg.sv
`default_nettype none

package vec_geom_pkg;

    localparam int LANE_WIDTH = 8;

    // element width code, values as in the original ALU
    typedef enum logic [1:0] {
        WW_BYTE   = 2'd0,
        WW_HALF   = 2'd1,
        WW_WORD   = 2'd2,
        WW_DOUBLE = 2'd3
    } ww_e;

    function automatic int unsigned elem_bytes(ww_e ww);
        int unsigned n;
        case (ww)
            WW_BYTE: n = 1;
            WW_HALF: n = 2;
            WW_WORD: n = 4;
            default: n = 8;
        endcase
        return n;
    endfunction

    function automatic int unsigned elem_bits(ww_e ww);
        return elem_bytes(ww) * LANE_WIDTH;
    endfunction

    // lane starts a new element; element size is a power of two
    function automatic logic elem_first(int unsigned lane, ww_e ww);
        int unsigned mask;
        mask = elem_bytes(ww) - 1;
        return (lane & mask) == 0;
    endfunction

    // lane holds the top byte of its element
    function automatic logic elem_last(int unsigned lane, ww_e ww);
        int unsigned mask;
        mask = elem_bytes(ww) - 1;
        return (lane & mask) == mask;
    endfunction

endpackage

`default_nettype wire

//--- rtl/vec_op_pkg.sv
`default_nettype none

package vec_op_pkg;

    // opcodes kept from the original instruction set
    // multiply, square, divide, modulo, sqrt and shifts decode as unsupported
    typedef enum logic [5:0] {
        OP_AND  = 6'd1,
        OP_OR   = 6'd2,
        OP_XOR  = 6'd3,
        OP_NOT  = 6'd4,
        OP_MOV  = 6'd5,
        OP_ADD  = 6'd6,
        OP_SUB  = 6'd7,
        OP_RTTH = 6'd13
    } vec_op_e;

    // what a single byte lane does
    typedef enum logic [2:0] {
        LANE_ZERO = 3'd0,
        LANE_AND  = 3'd1,
        LANE_OR   = 3'd2,
        LANE_XOR  = 3'd3,
        LANE_NOT  = 3'd4,
        LANE_PASS = 3'd5,
        LANE_ADD  = 3'd6,
        LANE_SUB  = 3'd7
    } lane_op_e;

    function automatic logic lane_is_arith(lane_op_e op);
        return (op == LANE_ADD) || (op == LANE_SUB);
    endfunction

endpackage

`default_nettype wire

//--- rtl/vec_operand_issue.sv
`default_nettype none

module vec_operand_issue
    import vec_geom_pkg::*;
    import vec_op_pkg::*;
#(
    parameter int DATA_WIDTH = 64
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                in_valid,
    output logic                                in_ready,
    input  vec_op_e                             in_op,
    input  ww_e                                 in_ww,
    input  logic [DATA_WIDTH-1:0]               in_a,
    input  logic [DATA_WIDTH-1:0]               in_b,

    output logic                                s1_valid,
    input  logic                                s2_ready,
    output lane_op_e                            lane_op,
    output logic [DATA_WIDTH-1:0]               lane_a,
    output logic [DATA_WIDTH-1:0]               lane_b,
    output logic [DATA_WIDTH/LANE_WIDTH-1:0]    lane_first
);

    localparam int NUM_LANES = DATA_WIDTH / LANE_WIDTH;

    logic                   load;
    lane_op_e               dec_op;
    logic [DATA_WIDTH-1:0]  rot_a;
    logic [DATA_WIDTH-1:0]  dec_a;
    logic [NUM_LANES-1:0]   dec_first;

    assign in_ready = !s1_valid || s2_ready;  // empty or draining this cycle
    assign load     = in_valid && in_ready;

    // opcode to lane operation
    always_comb begin
        case (in_op)
            OP_AND:  dec_op = LANE_AND;
            OP_OR:   dec_op = LANE_OR;
            OP_XOR:  dec_op = LANE_XOR;
            OP_NOT:  dec_op = LANE_NOT;
            OP_MOV:  dec_op = LANE_PASS;
            OP_ADD:  dec_op = LANE_ADD;
            OP_SUB:  dec_op = LANE_SUB;
            OP_RTTH: dec_op = LANE_PASS;  // lanes just pass the permuted A
            default: dec_op = LANE_ZERO;
        endcase
    end

    // swap the two halves of every element
    always_comb begin
        rot_a = in_a;
        case (in_ww)
            WW_BYTE: begin
                for (int i = 0; i < DATA_WIDTH; i += 8) begin
                    rot_a[i +: 8] = {in_a[i +: 4], in_a[i + 4 +: 4]};
                end
            end
            WW_HALF: begin
                for (int i = 0; i < DATA_WIDTH; i += 16) begin
                    rot_a[i +: 16] = {in_a[i +: 8], in_a[i + 8 +: 8]};
                end
            end
            WW_WORD: begin
                for (int i = 0; i < DATA_WIDTH; i += 32) begin
                    rot_a[i +: 32] = {in_a[i +: 16], in_a[i + 16 +: 16]};
                end
            end
            default: begin
                for (int i = 0; i < DATA_WIDTH; i += 64) begin
                    rot_a[i +: 64] = {in_a[i +: 32], in_a[i + 32 +: 32]};
                end
            end
        endcase
    end

    assign dec_a = (in_op == OP_RTTH) ? rot_a : in_a;

    // element boundaries, where the carry chain breaks
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            dec_first[l] = elem_first(l, in_ww);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            lane_op    <= dec_op;
            lane_a     <= dec_a;
            lane_b     <= in_b;
            lane_first <= dec_first;
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_byte_lane.sv
`default_nettype none

module vec_byte_lane
    import vec_geom_pkg::*;
    import vec_op_pkg::*;
(
    input  lane_op_e                lane_op,
    input  logic [LANE_WIDTH-1:0]   a,
    input  logic [LANE_WIDTH-1:0]   b,
    input  logic                    first,
    input  logic                    carry_in,
    output logic [LANE_WIDTH-1:0]   result,
    output logic                    carry_out
);

    logic                   is_sub;
    logic                   cin;
    logic [LANE_WIDTH-1:0]  b_eff;
    logic [LANE_WIDTH-1:0]  sum;

    assign is_sub = (lane_op == LANE_SUB);

    // sub is a + ~b + 1, the +1 enters at the element's low byte
    assign b_eff = is_sub ? ~b : b;
    assign cin   = first ? is_sub : carry_in;

    assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{LANE_WIDTH{1'b0}}, cin};

    always_comb begin
        case (lane_op)
            LANE_AND:  result = a & b;
            LANE_OR:   result = a | b;
            LANE_XOR:  result = a ^ b;
            LANE_NOT:  result = ~a;
            LANE_PASS: result = a;
            LANE_ADD,
            LANE_SUB:  result = sum;
            default:   result = '0;  // unsupported opcode
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/vec_result_collect.sv
`default_nettype none

module vec_result_collect #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    s1_valid,
    output logic                    s2_ready,
    input  logic [DATA_WIDTH-1:0]   lane_result,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_WIDTH-1:0]   out_data
);

    logic load;

    // free when empty or when the held item leaves this cycle
    assign s2_ready = !out_valid || out_ready;
    assign load     = s1_valid && s2_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (s2_ready) begin
            out_valid <= s1_valid;  // drops on transfer unless refilled
        end
    end

    // held while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= lane_result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_alu_top.sv
`default_nettype none

module vec_alu_top
    import vec_geom_pkg::*;
    import vec_op_pkg::*;
#(
    parameter int DATA_WIDTH = 64
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  vec_op_e                 in_op,
    input  ww_e                     in_ww,
    input  logic [DATA_WIDTH-1:0]   in_a,
    input  logic [DATA_WIDTH-1:0]   in_b,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_WIDTH-1:0]   out_data
);

    localparam int NUM_LANES = DATA_WIDTH / LANE_WIDTH;

    logic                   s1_valid;
    logic                   s2_ready;
    lane_op_e               lane_op;
    logic [DATA_WIDTH-1:0]  lane_a;
    logic [DATA_WIDTH-1:0]  lane_b;
    logic [NUM_LANES-1:0]   lane_first;
    logic [DATA_WIDTH-1:0]  lane_result;
    logic [NUM_LANES:0]     carry;  // carry[i] into lane i

    assign carry[0] = 1'b0;  // lane 0 always starts an element

    vec_operand_issue #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_ww      (in_ww),
        .in_a       (in_a),
        .in_b       (in_b),
        .s1_valid   (s1_valid),
        .s2_ready   (s2_ready),
        .lane_op    (lane_op),
        .lane_a     (lane_a),
        .lane_b     (lane_b),
        .lane_first (lane_first)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        vec_byte_lane u_lane (
            .lane_op   (lane_op),
            .a         (lane_a[i*LANE_WIDTH +: LANE_WIDTH]),
            .b         (lane_b[i*LANE_WIDTH +: LANE_WIDTH]),
            .first     (lane_first[i]),
            .carry_in  (carry[i]),
            .result    (lane_result[i*LANE_WIDTH +: LANE_WIDTH]),
            .carry_out (carry[i+1])
        );
    end

    vec_result_collect #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_collect (
        .clk         (clk),
        .arst_n      (arst_n),
        .s1_valid    (s1_valid),
        .s2_ready    (s2_ready),
        .lane_result (lane_result),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

//--- test/vec_alu_model.svh
`ifndef VEC_ALU_MODEL_SVH
`define VEC_ALU_MODEL_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

function automatic int model_elem_bits(input logic [1:0] ww);
    return 8 << ww;  // 8, 16, 32, 64
endfunction

// element-wise add or sub, each element wraps on its own
function automatic logic [DATA_WIDTH-1:0] model_arith(input logic sub, input int esz,
                                                      input logic [DATA_WIDTH-1:0] a,
                                                      input logic [DATA_WIDTH-1:0] b);
    logic [DATA_WIDTH-1:0] mask;
    logic [DATA_WIDTH-1:0] ea;
    logic [DATA_WIDTH-1:0] eb;
    logic [DATA_WIDTH-1:0] e;
    logic [DATA_WIDTH-1:0] r;
    mask = '1;
    mask = mask >> (DATA_WIDTH - esz);
    r = '0;
    for (int off = 0; off < DATA_WIDTH; off += esz) begin
        ea = (a >> off) & mask;
        eb = (b >> off) & mask;
        e  = sub ? (ea - eb) : (ea + eb);
        r  = r | ((e & mask) << off);
    end
    return r;
endfunction

function automatic logic [DATA_WIDTH-1:0] model_swap_halves(input int esz,
                                                            input logic [DATA_WIDTH-1:0] a);
    logic [DATA_WIDTH-1:0] mask;
    logic [DATA_WIDTH-1:0] e;
    logic [DATA_WIDTH-1:0] r;
    int half;
    mask = '1;
    mask = mask >> (DATA_WIDTH - esz);
    half = esz / 2;
    r = '0;
    for (int off = 0; off < DATA_WIDTH; off += esz) begin
        e = (a >> off) & mask;
        r = r | ((((e >> half) | (e << half)) & mask) << off);
    end
    return r;
endfunction

function automatic logic [DATA_WIDTH-1:0] model_result(input logic [5:0] op,
                                                       input logic [1:0] ww,
                                                       input logic [DATA_WIDTH-1:0] a,
                                                       input logic [DATA_WIDTH-1:0] b);
    logic [DATA_WIDTH-1:0] r;
    case (op)
        6'd1:    r = a & b;
        6'd2:    r = a | b;
        6'd3:    r = a ^ b;
        6'd4:    r = ~a;
        6'd5:    r = a;
        6'd6:    r = model_arith(1'b0, model_elem_bits(ww), a, b);
        6'd7:    r = model_arith(1'b1, model_elem_bits(ww), a, b);
        6'd13:   r = model_swap_halves(model_elem_bits(ww), a);
        default: r = '0;
    endcase
    return r;
endfunction

`endif

//--- test/tb_vec_alu.sv
`default_nettype none

module tb_vec_alu
    import vec_geom_pkg::*;
    import vec_op_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH     = 64;
    localparam int NUM_ITEMS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_ITEMS * 20 + 100;

    logic                   clk;
    logic                   arst_n;
    logic                   in_valid;
    logic                   in_ready;
    vec_op_e                in_op;
    ww_e                    in_ww;
    logic [DATA_WIDTH-1:0]  in_a;
    logic [DATA_WIDTH-1:0]  in_b;
    logic                   out_valid;
    logic                   out_ready;
    logic [DATA_WIDTH-1:0]  out_data;

    logic [31:0]            lfsr_state = 32'd92;
    logic                   in_fire = 1'b0;
    logic                   stalled = 1'b0;
    logic [DATA_WIDTH-1:0]  held_data;
    logic [DATA_WIDTH-1:0]  expected_q[$];
    logic [5:0]             op_q[$];
    logic [1:0]             ww_q[$];
    int                     n_offered = 0;
    int                     n_accepted = 0;
    int                     n_received = 0;
    int                     cycle_count = 0;

    vec_op_e    kept_ops[8]  = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_MOV, OP_ADD, OP_SUB, OP_RTTH};
    logic [5:0] unsup_ops[8] = '{6'd0, 6'd8, 6'd9, 6'd10, 6'd14, 6'd16, 6'd18, 6'd63};

    vec_alu_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_ww     (in_ww),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // one lfsr step per bit, newest bit lands at the lsb
    task automatic take_bits(input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};
        end
    endtask

    task automatic pick_item();
        logic [63:0] r;
        take_bits(4, r);
        if (r[3:0] < 4'd14) begin
            in_op = kept_ops[r[2:0]];
        end else begin
            take_bits(3, r);  // some unsupported opcodes
            in_op = vec_op_e'(unsup_ops[r[2:0]]);
        end
        take_bits(2, r);
        in_ww = ww_e'(r[1:0]);
        take_bits(64, r);
        in_a = r;
        take_bits(64, r);
        in_b = r;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout: not all items came out of the DUT");
        end
    end

    // scoreboard, sampled before the DUT registers update
    always @(posedge clk) begin
        if (arst_n) begin
            if (stalled) begin
                if (out_valid !== 1'b1) begin
                    report_failure("out_valid dropped while the output was stalled");
                end
                check_data("stall hold", held_data, out_data);
            end
            stalled   = out_valid && !out_ready;
            held_data = out_data;

            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    report_failure("DUT produced an output with no item pending");
                end
                check_data($sformatf("op %0d ww %0d item %0d", op_q[0], ww_q[0], n_received),
                           expected_q.pop_front(), out_data);
                void'(op_q.pop_front());
                void'(ww_q.pop_front());
                n_received++;
            end

            in_fire = in_valid && in_ready;
            if (in_fire) begin
                expected_q.push_back(model_result(in_op, in_ww, in_a, in_b));
                op_q.push_back(in_op);
                ww_q.push_back(in_ww);
                n_accepted++;
            end
        end
    end

    initial begin
        logic [63:0] r;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_op     = OP_AND;
        in_ww     = WW_BYTE;
        in_a      = '0;
        in_b      = '0;
        out_ready = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        @(negedge clk);
        if (out_valid !== 1'b0) begin
            report_failure("out_valid is not low after reset");
        end
        if (in_ready !== 1'b1) begin
            report_failure("in_ready is not high after reset");
        end

        // run until the last offered item has been taken
        while (n_offered < NUM_ITEMS || (in_valid && !in_fire)) begin
            take_bits(2, r);
            out_ready = (r[1:0] != 2'b00);
            if (!in_valid || in_fire) begin  // hold an offered item until taken
                in_valid = 1'b0;
                if (n_offered < NUM_ITEMS) begin
                    take_bits(2, r);
                    if (r[1:0] != 2'b00) begin
                        pick_item();
                        in_valid = 1'b1;
                        n_offered++;
                    end
                end
            end
            @(negedge clk);
        end

        // at most two items in flight, each leaves one cycle later
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (2) @(negedge clk);

        check_count("items received", n_accepted, n_received);
        $display("*** PASSED ***");
        $finish;
    end

    `include "vec_alu_model.svh"

endmodule

`default_nettype wire

//--- build.f
+incdir+test
rtl/vec_geom_pkg.sv
rtl/vec_op_pkg.sv
rtl/vec_operand_issue.sv
rtl/vec_byte_lane.sv
rtl/vec_result_collect.sv
rtl/vec_alu_top.sv
test/tb_vec_alu.sv

//--- Bender.yml
package:
  name: vec_alu

sources:
  - files:
      - rtl/vec_geom_pkg.sv
      - rtl/vec_op_pkg.sv
      - rtl/vec_operand_issue.sv
      - rtl/vec_byte_lane.sv
      - rtl/vec_result_collect.sv
      - rtl/vec_alu_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_vec_alu.sv
